// ==== tb.f ====
design/div_sqrt_pkg.sv
design/unit_issue_if.sv
design/unit_wb_if.sv
design/iter_divider.sv
design/iter_sqrt.sv
design/div_sqrt_unit.sv
design/div_sqrt_top.sv
tests/div_sqrt_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module div_sqrt_tb -f tb.f -o div_sqrt_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/div_sqrt_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0

// ==== tests/div_sqrt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_sqrt_tb;

  typedef enum logic [1:0] {
    ACK_LOW,
    ACK_HIGH,
    ACK_RANDOM
  } ack_mode_e;

  localparam int WAIT_LIMIT = 500;
  localparam int NUM_IDS = 2 ** div_sqrt_pkg::ID_W;

  logic                            clk;
  logic                            rst_n;
  logic                            req_valid;
  logic                            req_ready;
  logic [div_sqrt_pkg::ID_W-1:0]   req_id;
  div_sqrt_pkg::div_sqrt_op_e      req_op;
  logic [div_sqrt_pkg::DATA_W-1:0] req_a;
  logic [div_sqrt_pkg::DATA_W-1:0] req_b;
  logic                            wb_done;
  logic                            wb_ack;
  logic [div_sqrt_pkg::ID_W-1:0]   wb_id;
  logic [div_sqrt_pkg::DATA_W-1:0] wb_result;
  logic [div_sqrt_pkg::FLAG_W-1:0] wb_flags;

  ack_mode_e ack_mode;
  int        sent;

  // the reference model keeps results, flags and pending bits per id.
  logic [div_sqrt_pkg::DATA_W-1:0] exp_result [NUM_IDS];
  logic [div_sqrt_pkg::FLAG_W-1:0] exp_flags [NUM_IDS];
  logic                            pending [NUM_IDS];
  logic                            div_busy;
  logic                            sqrt_busy;
  logic [div_sqrt_pkg::ID_W-1:0]   div_id;
  logic [div_sqrt_pkg::ID_W-1:0]   sqrt_id;
  int                              div_start;
  int                              sqrt_start;
  int                              cycle_cnt;
  int                              issued_cnt;
  int                              retired_cnt;
  int                              div_age;
  int                              sqrt_age;
  logic                            div_done_m;
  logic                            sqrt_done_m;
  logic [div_sqrt_pkg::ID_W-1:0]   shown_id_m;
  logic                            result_ok;
  logic                            id_pending;

  div_sqrt_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_id    (req_id),
    .req_op    (req_op),
    .req_a     (req_a),
    .req_b     (req_b),
    .wb_done   (wb_done),
    .wb_ack    (wb_ack),
    .wb_id     (wb_id),
    .wb_result (wb_result),
    .wb_flags  (wb_flags)
  );

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped after a failed check");
  endtask

  task automatic flag_mismatch(input string what);
    stop_with_failure($sformatf("Error at %0t: %s", $time, what));
  endtask

  function automatic logic [div_sqrt_pkg::DATA_W-1:0] floor_root(
      input logic [div_sqrt_pkg::DATA_W-1:0] a);
    logic [div_sqrt_pkg::DATA_W-1:0] r;
    logic [div_sqrt_pkg::DATA_W-1:0] t;
    r = '0;
    // keep each root bit whose square still fits under a.
    for (int k = div_sqrt_pkg::DATA_W / 2 - 1; k >= 0; k--) begin
      t = r | (32'd1 << k);
      if (64'(t) * 64'(t) <= 64'(a)) begin
        r = t;
      end
    end
    return r;
  endfunction

  function automatic logic [div_sqrt_pkg::DATA_W-1:0] expected_result(
      input div_sqrt_pkg::div_sqrt_op_e op, input logic [div_sqrt_pkg::DATA_W-1:0] a,
      input logic [div_sqrt_pkg::DATA_W-1:0] b);
    if (op == div_sqrt_pkg::OP_SQRT) begin
      return floor_root(a);
    end
    if (b == '0) begin
      return '1;
    end
    return a / b;
  endfunction

  function automatic logic [div_sqrt_pkg::FLAG_W-1:0] expected_flags(
      input div_sqrt_pkg::div_sqrt_op_e op, input logic [div_sqrt_pkg::DATA_W-1:0] a,
      input logic [div_sqrt_pkg::DATA_W-1:0] b);
    logic [div_sqrt_pkg::DATA_W-1:0] root;
    logic [div_sqrt_pkg::FLAG_W-1:0] f;
    f = '0;
    if (op == div_sqrt_pkg::OP_SQRT) begin
      root = floor_root(a);
      f[div_sqrt_pkg::FLAG_NX] = 64'(root) * 64'(root) != 64'(a);
    end else begin
      f[div_sqrt_pkg::FLAG_DZ] = b == '0;
      f[div_sqrt_pkg::FLAG_NX] = b != '0 && a % b != '0;
    end
    return f;
  endfunction

  // waits for req_ready, then holds the request for the accepting edge.
  task automatic issue_request(input div_sqrt_pkg::div_sqrt_op_e op,
      input logic [div_sqrt_pkg::DATA_W-1:0] a, input logic [div_sqrt_pkg::DATA_W-1:0] b);
    int waited;
    waited = 0;
    @(posedge clk);
    while (!req_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_with_failure("timeout: req_ready never came back high");
      end
      @(posedge clk);
    end
    req_valid <= 1'b1;
    req_op <= op;
    req_id <= div_sqrt_pkg::ID_W'(sent);
    req_a <= a;
    req_b <= b;
    sent++;
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_for_result(input logic [div_sqrt_pkg::ID_W-1:0] id);
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_with_failure("timeout: an id never reached the writeback port");
      end
    end while (!(wb_done && wb_id == id));
  endtask

  task automatic wait_all_retired();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_with_failure("timeout: issued operations were never written back");
      end
    end while (issued_cnt != retired_cnt);
  endtask

  // done rises on the last latency edge and is first sampled one edge later.
  assign div_age = cycle_cnt - div_start;
  assign sqrt_age = cycle_cnt - sqrt_start;
  assign div_done_m = div_busy && div_age > div_sqrt_pkg::DIV_ITER + 1;
  assign sqrt_done_m = sqrt_busy && sqrt_age > div_sqrt_pkg::SQRT_ITER + 1;
  assign shown_id_m = div_done_m ? div_id : sqrt_id;
  assign result_ok = wb_result == exp_result[wb_id] && wb_flags == exp_flags[wb_id];
  assign id_pending = pending[wb_id];

  always @(posedge clk) begin
    if (!rst_n) begin
      cycle_cnt <= 0;
      issued_cnt <= 0;
      retired_cnt <= 0;
      div_busy <= 1'b0;
      sqrt_busy <= 1'b0;
      for (int i = 0; i < NUM_IDS; i++) begin
        pending[i] <= 1'b0;
      end
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      // a unit takes a request whenever it is idle itself.
      if (req_valid && (req_op == div_sqrt_pkg::OP_DIV ? !div_busy : !sqrt_busy)) begin
        pending[req_id] <= 1'b1;
        exp_result[req_id] <= expected_result(req_op, req_a, req_b);
        exp_flags[req_id] <= expected_flags(req_op, req_a, req_b);
        issued_cnt <= issued_cnt + 1;
        if (req_op == div_sqrt_pkg::OP_DIV) begin
          div_busy <= 1'b1;
          div_id <= req_id;
          div_start <= cycle_cnt;
        end else begin
          sqrt_busy <= 1'b1;
          sqrt_id <= req_id;
          sqrt_start <= cycle_cnt;
        end
      end
      if (wb_done && wb_ack) begin
        pending[wb_id] <= 1'b0;
        retired_cnt <= retired_cnt + 1;
        if (div_done_m) begin
          div_busy <= 1'b0;
        end else begin
          sqrt_busy <= 1'b0;
        end
      end
    end
  end

  assert property (@(posedge clk) $rose(rst_n) |-> !wb_done && req_ready)
    else flag_mismatch("wrong wb_done or req_ready right after reset");

  assert property (@(posedge clk) disable iff (!rst_n)
    req_ready == (!div_busy && !sqrt_busy))
    else flag_mismatch("req_ready does not match the busy state of the units");

  assert property (@(posedge clk) disable iff (!rst_n)
    wb_done == (div_done_m || sqrt_done_m))
    else flag_mismatch("wb_done does not match the expected latency");

  assert property (@(posedge clk) disable iff (!rst_n) wb_done |-> wb_id == shown_id_m)
    else flag_mismatch("wrong id on the writeback port");

  assert property (@(posedge clk) disable iff (!rst_n) wb_done |-> result_ok)
    else flag_mismatch("wrong result or flags on the writeback port");

  assert property (@(posedge clk) disable iff (!rst_n) wb_done && wb_ack |-> id_pending)
    else flag_mismatch("an id was written back more than once");

  // only a divide that finishes may replace a result waiting for ack.
  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_done && !wb_ack) |=> wb_done &&
      (($stable(wb_id) && $stable(wb_result) && $stable(wb_flags)) || $rose(div_done_m)))
    else flag_mismatch("writeback changed while ack was low");

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    wb_ack = 1'b0;
    forever begin
      @(posedge clk);
      case (ack_mode)
        ACK_LOW: wb_ack <= 1'b0;
        ACK_HIGH: wb_ack <= 1'b1;
        default: wb_ack <= ($urandom % 3) == 0;
      endcase
    end
  end

  initial begin
    int unsigned seed;
    logic [div_sqrt_pkg::ID_W-1:0] div_tag;
    logic op_bit;
    logic [div_sqrt_pkg::DATA_W-1:0] a;
    logic [div_sqrt_pkg::DATA_W-1:0] b;
    seed = 32'haf96bc07;
    void'($urandom(seed));
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_id = '0;
    req_op = div_sqrt_pkg::OP_DIV;
    req_a = '0;
    req_b = '0;
    ack_mode = ACK_HIGH;
    sent = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    issue_request(div_sqrt_pkg::OP_DIV, 32'd100, 32'd7);
    issue_request(div_sqrt_pkg::OP_DIV, 32'd84, 32'd7);
    issue_request(div_sqrt_pkg::OP_DIV, 32'd5, 32'd9);
    issue_request(div_sqrt_pkg::OP_DIV, 32'd123, 32'd0);
    issue_request(div_sqrt_pkg::OP_DIV, 32'd0, 32'd0);
    issue_request(div_sqrt_pkg::OP_DIV, 32'hffff_ffff, 32'd1);
    issue_request(div_sqrt_pkg::OP_DIV, 32'hffff_ffff, 32'hffff_ffff);
    issue_request(div_sqrt_pkg::OP_SQRT, 32'd0, 32'd0);
    issue_request(div_sqrt_pkg::OP_SQRT, 32'd144, 32'd0);
    issue_request(div_sqrt_pkg::OP_SQRT, 32'd2, 32'd0);
    issue_request(div_sqrt_pkg::OP_SQRT, 32'hfffe_0001, 32'd0);
    issue_request(div_sqrt_pkg::OP_SQRT, 32'hffff_ffff, 32'd0);
    wait_all_retired();

    // a square root goes first and the idle divider takes a divide right after it.
    ack_mode <= ACK_LOW;
    issue_request(div_sqrt_pkg::OP_SQRT, 32'd1000000, 32'd0);
    div_tag = div_sqrt_pkg::ID_W'(sent);
    req_valid <= 1'b1;
    req_op <= div_sqrt_pkg::OP_DIV;
    req_id <= div_tag;
    req_a <= 32'd1000;
    req_b <= 32'd3;
    sent++;
    @(posedge clk);
    req_valid <= 1'b0;
    wait_for_result(div_tag);
    repeat (4) @(posedge clk);
    ack_mode <= ACK_HIGH;
    wait_all_retired();

    ack_mode <= ACK_RANDOM;
    repeat (150) begin
      op_bit = 1'($urandom);
      a = $urandom;
      b = ($urandom % 4 == 0) ? $urandom % 16 : $urandom;
      issue_request(div_sqrt_pkg::div_sqrt_op_e'(op_bit), a, b);
    end
    wait_all_retired();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/div_sqrt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_sqrt_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            req_valid,
  output logic                            req_ready,
  input  logic [div_sqrt_pkg::ID_W-1:0]   req_id,
  input  div_sqrt_pkg::div_sqrt_op_e      req_op,
  input  logic [div_sqrt_pkg::DATA_W-1:0] req_a,
  input  logic [div_sqrt_pkg::DATA_W-1:0] req_b,
  output logic                            wb_done,
  input  logic                            wb_ack,
  output logic [div_sqrt_pkg::ID_W-1:0]   wb_id,
  output logic [div_sqrt_pkg::DATA_W-1:0] wb_result,
  output logic [div_sqrt_pkg::FLAG_W-1:0] wb_flags
);

  unit_issue_if issue_bus();
  unit_wb_if    wb_bus();

  assign issue_bus.new_request = req_valid;
  assign issue_bus.id = req_id;
  assign issue_bus.rs1 = req_a;
  assign issue_bus.rs2 = req_b;
  assign req_ready = issue_bus.ready;

  assign wb_done = wb_bus.done;
  assign wb_id = wb_bus.id;
  assign wb_result = wb_bus.result;
  assign wb_flags = wb_bus.flags;
  assign wb_bus.ack = wb_ack;

  div_sqrt_unit unit (
    .clk   (clk),
    .rst_n (rst_n),
    .op    (req_op),
    .issue (issue_bus),
    .wb    (wb_bus)
  );

endmodule

`default_nettype wire

// ==== design/div_sqrt_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_sqrt_unit (
  input logic                       clk,
  input logic                       rst_n,
  input div_sqrt_pkg::div_sqrt_op_e op,
  unit_issue_if.unit                issue,
  unit_wb_if.unit                   wb
);

  unit_issue_if div_issue();
  unit_issue_if sqrt_issue();
  unit_wb_if    div_wb();
  unit_wb_if    sqrt_wb();

  iter_divider div (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (div_issue),
    .wb    (div_wb)
  );

  iter_sqrt sqrt (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (sqrt_issue),
    .wb    (sqrt_wb)
  );

  // both units see the operands; only the selected one gets the request.
  assign issue.ready = div_issue.ready & sqrt_issue.ready;
  assign div_issue.id = issue.id;
  assign sqrt_issue.id = issue.id;
  assign div_issue.rs1 = issue.rs1;
  assign sqrt_issue.rs1 = issue.rs1;
  assign div_issue.rs2 = issue.rs2;
  assign sqrt_issue.rs2 = issue.rs2;
  assign div_issue.new_request = issue.new_request && op == div_sqrt_pkg::OP_DIV;
  assign sqrt_issue.new_request = issue.new_request && op == div_sqrt_pkg::OP_SQRT;

  // the divider wins when both are done. The square root result waits.
  always_comb begin
    div_wb.ack = wb.ack & div_wb.done;
    sqrt_wb.ack = wb.ack & ~div_wb.done;
    if (div_wb.done) begin
      wb.done = div_wb.done;
      wb.id = div_wb.id;
      wb.result = div_wb.result;
      wb.flags = div_wb.flags;
    end else begin
      wb.done = sqrt_wb.done;
      wb.id = sqrt_wb.id;
      wb.result = sqrt_wb.result;
      wb.flags = sqrt_wb.flags;
    end
  end

endmodule

`default_nettype wire

// ==== design/iter_sqrt.sv ====
`timescale 1ns/1ps
`default_nettype none

module iter_sqrt (
  input logic        clk,
  input logic        rst_n,
  unit_issue_if.unit issue,
  unit_wb_if.unit    wb
);

  div_sqrt_pkg::unit_state_e                 state;
  logic [div_sqrt_pkg::SQRT_CNT_W-1:0]       cnt;
  logic [div_sqrt_pkg::ID_W-1:0]             id_q;
  logic [div_sqrt_pkg::DATA_W-1:0]           radicand;
  logic [div_sqrt_pkg::ROOT_W-1:0]           root;
  logic [div_sqrt_pkg::SQRT_REM_W-1:0]       rem;
  logic [div_sqrt_pkg::SQRT_REM_W+1:0]       rem_shift;
  logic [div_sqrt_pkg::SQRT_REM_W+1:0]       trial;
  logic [div_sqrt_pkg::SQRT_REM_W+1:0]       rem_diff;
  logic                                      fits;
  logic                                      last_step;

  // bring down the next two radicand bits and try 4*root + 1.
  assign rem_shift = {rem, radicand[div_sqrt_pkg::DATA_W-1 -: 2]};
  assign trial = {2'b00, root, 2'b01};
  assign rem_diff = rem_shift - trial;
  assign fits = rem_shift >= trial;
  assign last_step = cnt == div_sqrt_pkg::SQRT_CNT_W'(div_sqrt_pkg::SQRT_ITER);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= div_sqrt_pkg::ST_IDLE;
      cnt <= '0;
    end else begin
      case (state)
        div_sqrt_pkg::ST_IDLE: begin
          if (issue.new_request) begin
            state <= div_sqrt_pkg::ST_BUSY;
            cnt <= '0;
          end
        end
        div_sqrt_pkg::ST_BUSY: begin
          if (last_step) begin
            state <= div_sqrt_pkg::ST_DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        div_sqrt_pkg::ST_DONE: begin
          if (wb.ack) begin
            state <= div_sqrt_pkg::ST_IDLE;
          end
        end
        default: state <= div_sqrt_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == div_sqrt_pkg::ST_IDLE && issue.new_request) begin
      radicand <= issue.rs1;
      root <= '0;
      rem <= '0;
      id_q <= issue.id;
    end else if (state == div_sqrt_pkg::ST_BUSY && !last_step) begin
      // the remainder never exceeds 2*root, so the low bits hold it.
      if (fits) begin
        rem <= rem_diff[div_sqrt_pkg::SQRT_REM_W-1:0];
      end else begin
        rem <= rem_shift[div_sqrt_pkg::SQRT_REM_W-1:0];
      end
      root <= {root[div_sqrt_pkg::ROOT_W-2:0], fits};
      radicand <= {radicand[div_sqrt_pkg::DATA_W-3:0], 2'b00};
    end
  end

  assign issue.ready = state == div_sqrt_pkg::ST_IDLE;

  assign wb.done = state == div_sqrt_pkg::ST_DONE;
  assign wb.id = id_q;
  assign wb.result = {{(div_sqrt_pkg::DATA_W - div_sqrt_pkg::ROOT_W){1'b0}}, root};

  always_comb begin
    wb.flags = '0;
    wb.flags[div_sqrt_pkg::FLAG_NX] = rem != '0;
  end

endmodule

`default_nettype wire

// ==== design/iter_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module iter_divider (
  input logic        clk,
  input logic        rst_n,
  unit_issue_if.unit issue,
  unit_wb_if.unit    wb
);

  div_sqrt_pkg::unit_state_e                state;
  logic [div_sqrt_pkg::DIV_CNT_W-1:0]       cnt;
  logic [div_sqrt_pkg::ID_W-1:0]            id_q;
  logic [div_sqrt_pkg::DATA_W-1:0]          divisor;
  logic [div_sqrt_pkg::DATA_W-1:0]          quot;
  logic [div_sqrt_pkg::DATA_W-1:0]          rem;
  logic [div_sqrt_pkg::DATA_W:0]            rem_shift;
  logic [div_sqrt_pkg::DATA_W:0]            rem_diff;
  logic                                     fits;
  logic                                     div_zero;

  // quot starts as the dividend and fills with quotient bits from the right.
  assign rem_shift = {rem, quot[div_sqrt_pkg::DATA_W-1]};
  assign rem_diff = rem_shift - {1'b0, divisor};
  assign fits = rem_shift >= {1'b0, divisor};
  assign div_zero = divisor == '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= div_sqrt_pkg::ST_IDLE;
      cnt <= '0;
    end else begin
      case (state)
        div_sqrt_pkg::ST_IDLE: begin
          if (issue.new_request) begin
            state <= div_sqrt_pkg::ST_BUSY;
            cnt <= '0;
          end
        end
        div_sqrt_pkg::ST_BUSY: begin
          // one extra cycle after the last quotient bit before done rises.
          if (cnt == div_sqrt_pkg::DIV_CNT_W'(div_sqrt_pkg::DIV_ITER)) begin
            state <= div_sqrt_pkg::ST_DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        div_sqrt_pkg::ST_DONE: begin
          if (wb.ack) begin
            state <= div_sqrt_pkg::ST_IDLE;
          end
        end
        default: state <= div_sqrt_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == div_sqrt_pkg::ST_IDLE && issue.new_request) begin
      divisor <= issue.rs2;
      quot <= issue.rs1;
      rem <= '0;
      id_q <= issue.id;
    end else if (state == div_sqrt_pkg::ST_BUSY &&
                 cnt != div_sqrt_pkg::DIV_CNT_W'(div_sqrt_pkg::DIV_ITER)) begin
      if (fits) begin
        rem <= rem_diff[div_sqrt_pkg::DATA_W-1:0];
      end else begin
        rem <= rem_shift[div_sqrt_pkg::DATA_W-1:0];
      end
      quot <= {quot[div_sqrt_pkg::DATA_W-2:0], fits};
    end
  end

  assign issue.ready = state == div_sqrt_pkg::ST_IDLE;

  assign wb.done = state == div_sqrt_pkg::ST_DONE;
  assign wb.id = id_q;
  // a zero divisor returns all ones, as RISC-V does.
  assign wb.result = div_zero ? '1 : quot;

  always_comb begin
    wb.flags = '0;
    wb.flags[div_sqrt_pkg::FLAG_DZ] = div_zero;
    wb.flags[div_sqrt_pkg::FLAG_NX] = !div_zero && (rem != '0);
  end

endmodule

`default_nettype wire

// ==== design/unit_wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface unit_wb_if;

  logic                            done;
  logic                            ack;
  logic [div_sqrt_pkg::ID_W-1:0]   id;
  logic [div_sqrt_pkg::DATA_W-1:0] result;
  logic [div_sqrt_pkg::FLAG_W-1:0] flags;

  modport unit (
    output done,
    output id,
    output result,
    output flags,
    input  ack
  );

  modport arbiter (
    input  done,
    input  id,
    input  result,
    input  flags,
    output ack
  );

endinterface

`default_nettype wire

// ==== design/unit_issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface unit_issue_if;

  logic                            new_request;
  logic                            ready;
  logic [div_sqrt_pkg::ID_W-1:0]   id;
  logic [div_sqrt_pkg::DATA_W-1:0] rs1;
  logic [div_sqrt_pkg::DATA_W-1:0] rs2;

  modport unit (
    input  new_request,
    input  id,
    input  rs1,
    input  rs2,
    output ready
  );

  modport dispatch (
    output new_request,
    output id,
    output rs1,
    output rs2,
    input  ready
  );

endinterface

`default_nettype wire

// ==== design/div_sqrt_pkg.sv ====
`default_nettype none

package div_sqrt_pkg;

  localparam int DATA_W = 32;
  localparam int ID_W = 3;
  localparam int FLAG_W = 2;

  // bit positions inside the flags field.
  localparam int FLAG_DZ = 0;
  localparam int FLAG_NX = 1;

  localparam int DIV_ITER = DATA_W;
  localparam int SQRT_ITER = DATA_W / 2;

  // the counters also hold the final value that marks the finishing cycle.
  localparam int DIV_CNT_W = $clog2(DIV_ITER + 1);
  localparam int SQRT_CNT_W = $clog2(SQRT_ITER + 1);

  // root width and the partial remainder width of the square root unit.
  localparam int ROOT_W = DATA_W / 2;
  localparam int SQRT_REM_W = ROOT_W + 2;

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } div_sqrt_op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_DONE = 2'd2
  } unit_state_e;

endpackage

`default_nettype wire
